/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
TOP       ?= pma_checker_tb
RTL_TOP   ?= pma_checker
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
+incdir+design
design/pma_pkg.sv
design/pma_napot_entry.sv
design/pma_entry_select.sv
design/pma_default_region.sv
design/pma_checker.sv
tests/pma_checker_tb.sv

/* design/pma_checker.sv */
// top level of the PMA checker: combinational attribute lookup for one physical request address
`include "pma_settings.svh"

module pma_checker
    import pma_pkg::*;
(
    input  logic          core_clk,
    input  logic          core_reset_n,
    input  pma_addr_t     pma_req_pa,
    input  logic          reg_pma_we,
    input  logic [7:0]    csr_pma_cfg [`PMA_NUM_ENTRIES],
    input  pma_csr_addr_t csr_pma_addr [`PMA_NUM_ENTRIES],
    output logic          pma_resp_fault,
    output pma_mtype_e    pma_resp_mtype,
    output logic          pma_resp_namo
);

    logic [`PMA_NUM_ENTRIES-1:0] entry_hit;
    logic                        sel_hit;
    pma_mtype_e                  sel_mtype;
    logic                        sel_namo;
    pma_mtype_e                  dflt_mtype;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // entries
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < `PMA_NUM_ENTRIES; i++) begin : gen_entry
        pma_etyp_e etyp;

        assign etyp = pma_etyp_e'(csr_pma_cfg[i][`PMA_CFG_ETYP_LSB +: pma_etyp_w]);

        pma_napot_entry u_entry (
            .core_clk     (core_clk),
            .core_reset_n (core_reset_n),
            .reg_pma_we   (reg_pma_we),
            .cfg_etyp     (etyp),
            .cfg_addr     (csr_pma_addr[i]),
            .req_pa       (pma_req_pa),
            .hit          (entry_hit[i])
        );
    end

    pma_entry_select u_entry_select (
        .entry_hit   (entry_hit),
        .csr_pma_cfg (csr_pma_cfg),
        .sel_hit     (sel_hit),
        .sel_mtype   (sel_mtype),
        .sel_namo    (sel_namo)
    );

    pma_default_region u_default_region (
        .req_pa     (pma_req_pa),
        .dflt_mtype (dflt_mtype)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // response merge
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pma_resp_mtype = sel_hit ? sel_mtype : dflt_mtype;

    // namo only comes from a programmed entry, the default map has none
    assign pma_resp_namo = sel_hit & sel_namo;

    assign pma_resp_fault = (pma_resp_mtype == mtype_black_hole);

    // black hole can only be programmed, the default map never yields it
    a_fault_needs_hit: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        !sel_hit |-> !pma_resp_fault
    ) else $error("fault raised from the default map for %h", pma_req_pa);

endmodule

/* design/pma_default_region.sv */
// fixed default memory map of the PMA checker, consulted by the top level when no entry matches
`include "pma_settings.svh"

module pma_default_region
    import pma_pkg::*;
(
    input  pma_addr_t  req_pa,
    output pma_mtype_e dflt_mtype
);

    localparam int msb     = `PMA_PALEN - 1;
    localparam int chk_lsb = `PMA_CHECK_LSB;

    localparam pma_addr_t dev_base = pma_addr_t'(`PMA_DEVICE_BASE);
    localparam pma_addr_t dev_mask = pma_addr_t'(`PMA_DEVICE_MASK);
    localparam pma_addr_t wt_base  = pma_addr_t'(`PMA_WT_BASE);
    localparam pma_addr_t wt_mask  = pma_addr_t'(`PMA_WT_MASK);

    logic is_device;
    logic is_wt;

    // page offset bits never take part in the region test
    function automatic logic in_region(
        input pma_addr_t pa,
        input pma_addr_t base,
        input pma_addr_t mask
    );
        return (pa[msb:chk_lsb] & mask[msb:chk_lsb]) == base[msb:chk_lsb];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // region decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign is_device = in_region(req_pa, dev_base, dev_mask);
    assign is_wt     = in_region(req_pa, wt_base, wt_mask);

    // device wins where the two regions would overlap
    always_comb begin
        if (is_device) begin
            dflt_mtype = mtype_device;
        end else if (is_wt) begin
            dflt_mtype = mtype_write_through;
        end else begin
            dflt_mtype = mtype_write_back;
        end
    end

endmodule

/* design/pma_entry_select.sv */
// fixed-priority selection of the first matching PMA entry, used by the checker top level
`include "pma_settings.svh"

module pma_entry_select
    import pma_pkg::*;
(
    input  logic [`PMA_NUM_ENTRIES-1:0] entry_hit,
    input  logic [7:0]                  csr_pma_cfg [`PMA_NUM_ENTRIES],
    output logic                        sel_hit,
    output pma_mtype_e                  sel_mtype,
    output logic                        sel_namo
);

    logic [`PMA_NUM_ENTRIES-1:0] first_hit;
    logic [`PMA_NUM_ENTRIES-1:0] cfg_namo;

    // any matching entry overrides the default map
    assign sel_hit = |entry_hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // priority scan
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        logic found;

        found     = 1'b0;
        sel_mtype = mtype_device;
        sel_namo  = 1'b0;

        // entry 0 has the highest priority
        for (int i = 0; i < `PMA_NUM_ENTRIES; i++) begin
            if (entry_hit[i] && !found) begin
                found     = 1'b1;
                sel_mtype = pma_mtype_e'(csr_pma_cfg[i][`PMA_CFG_MTYP_LSB +: pma_mtyp_w]);
                sel_namo  = csr_pma_cfg[i][`PMA_CFG_NAMO_BIT];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // priority cross-check
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the two's complement isolates the lowest set hit bit, which names the
    // winner without the scan and is all zeros when nothing hits
    assign first_hit = entry_hit & (-entry_hit);

    for (genvar i = 0; i < `PMA_NUM_ENTRIES; i++) begin : gen_namo
        assign cfg_namo[i] = csr_pma_cfg[i][`PMA_CFG_NAMO_BIT];
    end

    always_comb begin
        a_namo_from_first_hit: assert final (sel_namo == |(first_hit & cfg_namo))
            else $error("sel_namo does not come from the lowest matching entry");
    end

endmodule

/* design/pma_napot_entry.sv */
// one NAPOT entry of the PMA checker, instantiated once per entry by the top level
`include "pma_settings.svh"

module pma_napot_entry
    import pma_pkg::*;
(
    input  logic          core_clk,
    input  logic          core_reset_n,
    input  logic          reg_pma_we,
    input  pma_etyp_e     cfg_etyp,
    input  pma_csr_addr_t cfg_addr,
    input  pma_addr_t     req_pa,
    output logic          hit
);

    localparam int msb     = `PMA_PALEN - 1;
    localparam int fld_lsb = `PMA_CHECK_LSB - 1;
    localparam int chk_lsb = `PMA_CHECK_LSB;

    pma_mask_t           addr_fld;
    pma_mask_t           addr_inc;
    pma_mask_t           mask_next;
    pma_mask_t           mask_q;
    pma_mask_t           mask_inv;
    logic [msb:chk_lsb]  addr_diff;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // mask capture
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign addr_fld = cfg_addr[msb:fld_lsb];
    assign addr_inc = addr_fld + pma_mask_t'(1);

    // adding one flips the trailing ones and the lowest zero, so the xnor
    // leaves ones only above the lowest zero of the field
    assign mask_next = ~(addr_fld ^ addr_inc);

    always_ff @(posedge core_clk or negedge core_reset_n) begin
        if (!core_reset_n) begin
            mask_q <= '0;
        end else if (reg_pma_we) begin
            mask_q <= mask_next;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // match
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // the live address is compared under the captured mask, which stays
    // as it is until software pulses the strobe again
    assign addr_diff = (cfg_addr[msb:chk_lsb] ^ req_pa[msb:chk_lsb]) & mask_q[msb:chk_lsb];

    assign hit = (cfg_etyp == etyp_napot) && (addr_diff == '0);

    // a napot mask is ones from the top down then zeros, so its inverse
    // must be a run of ones from bit zero
    assign mask_inv = ~mask_q;

    a_mask_contiguous: assert property (
        @(posedge core_clk) disable iff (!core_reset_n)
        (mask_inv & (mask_inv + pma_mask_t'(1))) == '0
    ) else $error("napot mask is not a contiguous run of ones: %h", mask_q);

endmodule

/* design/pma_pkg.sv */
// shared types of the PMA checker, imported by every RTL module and by the testbench
`include "pma_settings.svh"

package pma_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // configuration field encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // only napot is matched, tor and na4 are decoded but never hit
    typedef enum logic [1:0] {
        etyp_off   = 2'd0,
        etyp_tor   = 2'd1,
        etyp_na4   = 2'd2,
        etyp_napot = 2'd3
    } pma_etyp_e;

    // other 4-bit codes written by software pass through unchanged
    typedef enum logic [3:0] {
        mtype_device        = 4'd0,
        mtype_write_through = 4'd5,
        mtype_write_back    = 4'd11,
        mtype_black_hole    = 4'd15
    } pma_mtype_e;

    localparam int pma_etyp_w = $bits(pma_etyp_e);
    localparam int pma_mtyp_w = $bits(pma_mtype_e);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address and mask types
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // physical byte address
    typedef logic [`PMA_PALEN-1:0] pma_addr_t;

    // address register holds the byte address shifted right by two,
    // indexed here by byte-address bit so slices line up with pma_addr_t
    typedef logic [`PMA_PALEN-1:2] pma_csr_addr_t;

    // stored match mask, one bit below the check boundary so the napot
    // size bit at byte bit 11 takes part in the increment
    typedef logic [`PMA_PALEN-1:`PMA_CHECK_LSB-1] pma_mask_t;

endpackage

/* design/pma_settings.svh */
// build-time constants for the PMA checker, included by the package and by every RTL module
`ifndef PMA_SETTINGS_SVH
`define PMA_SETTINGS_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// address space and entries
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define PMA_PALEN 34
`define PMA_NUM_ENTRIES 4

// matching ignores the 4 KiB page offset
`define PMA_CHECK_LSB 12

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// configuration byte layout
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`define PMA_CFG_ETYP_LSB 0
`define PMA_CFG_MTYP_LSB 2
`define PMA_CFG_NAMO_BIT 6

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// default map used when no entry matches
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

// upper half of the low 4 GiB is device space
`define PMA_DEVICE_BASE 64'h0000_0000_8000_0000
`define PMA_DEVICE_MASK 64'h0000_0000_8000_0000

// the 1 GiB below it is write-through
`define PMA_WT_BASE 64'h0000_0000_4000_0000
`define PMA_WT_MASK 64'h0000_0000_C000_0000

`endif

/* tests/pma_checker_tb.sv */
// self-checking testbench for the PMA checker, drives random lookups against a reference model
`include "pma_settings.svh"

module pma_checker_tb
    import pma_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int timeout_cycles = 6000;

    logic          core_clk;
    logic          core_reset_n;
    pma_addr_t     pma_req_pa;
    logic          reg_pma_we;
    logic [7:0]    csr_pma_cfg [`PMA_NUM_ENTRIES];
    pma_csr_addr_t csr_pma_addr [`PMA_NUM_ENTRIES];
    logic          pma_resp_fault;
    pma_mtype_e    pma_resp_mtype;
    logic          pma_resp_namo;

    // model state: captured masks and the regions each entry was given
    pma_mask_t     model_mask [`PMA_NUM_ENTRIES];
    pma_addr_t     ent_base [`PMA_NUM_ENTRIES];
    int            ent_k [`PMA_NUM_ENTRIES];
    logic [15:0]   lfsr_state;
    int            cycle_count = 0;

    pma_checker u_pma_checker (
        .core_clk       (core_clk),
        .core_reset_n   (core_reset_n),
        .pma_req_pa     (pma_req_pa),
        .reg_pma_we     (reg_pma_we),
        .csr_pma_cfg    (csr_pma_cfg),
        .csr_pma_addr   (csr_pma_addr),
        .pma_resp_fault (pma_resp_fault),
        .pma_resp_mtype (pma_resp_mtype),
        .pma_resp_namo  (pma_resp_namo)
    );

    initial begin
        core_clk = 1'b0;
        forever #4 core_clk = ~core_clk;
    end

    always @(posedge core_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout: the tests did not finish within %0d clock cycles", timeout_cycles);
            $display("Test failures found");
            $fatal(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // random numbers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // 16-bit fibonacci lfsr with taps 16, 14, 13 and 11
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int j = 0; j < n; j++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    // bits 31:30 are steered so all three default regions show up
    function automatic pma_addr_t rand_addr();
        pma_addr_t  a;
        logic [2:0] space;
        a = pma_addr_t'(rand_bits(`PMA_PALEN));
        space = 3'(rand_bits(3));
        if (space < 3'd3) begin
            a[31] = 1'b1;
        end else if (space < 3'd6) begin
            a[31:30] = 2'b01;
        end else begin
            a[31:30] = 2'b00;
        end
        if (2'(rand_bits(2)) != 2'b11) begin
            a[`PMA_PALEN-1:`PMA_PALEN-2] = 2'b00;
        end
        return a;
    endfunction

    function automatic pma_addr_t addr_in_region(input pma_addr_t base, input int k);
        pma_addr_t a;
        a = rand_addr();
        for (int b = k; b < `PMA_PALEN; b++) begin
            a[b] = base[b];
        end
        return a;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // configuration encoding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [7:0] make_cfg(input pma_etyp_e etyp, input pma_mtype_e mtyp,
                                            input logic namo);
        logic [7:0] c;
        c = 8'h00;
        c[`PMA_CFG_ETYP_LSB +: 2] = etyp;
        c[`PMA_CFG_MTYP_LSB +: 4] = mtyp;
        c[`PMA_CFG_NAMO_BIT] = namo;
        return c;
    endfunction

    // a region of 2**k bytes: ones below byte bit k-1, a zero at k-1
    function automatic pma_csr_addr_t napot_addr(input pma_addr_t base, input int k);
        pma_csr_addr_t a;
        a = base[`PMA_PALEN-1:2];
        for (int b = 2; b < k - 1; b++) begin
            a[b] = 1'b1;
        end
        a[k-1] = 1'b0;
        return a;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // every bit above the lowest zero of the size field is compared
    function automatic pma_mask_t mask_from_addr(input pma_csr_addr_t a);
        pma_mask_t m;
        logic      seen_zero;
        m = '0;
        seen_zero = 1'b0;
        for (int b = `PMA_CHECK_LSB - 1; b < `PMA_PALEN; b++) begin
            if (seen_zero) begin
                m[b] = 1'b1;
            end else if (!a[b]) begin
                seen_zero = 1'b1;
            end
        end
        return m;
    endfunction

    function automatic logic model_hit(input int idx, input pma_addr_t pa);
        pma_etyp_e etyp;
        logic      match;
        etyp = pma_etyp_e'(csr_pma_cfg[idx][`PMA_CFG_ETYP_LSB +: 2]);
        match = (etyp == etyp_napot);
        for (int b = `PMA_CHECK_LSB; b < `PMA_PALEN; b++) begin
            if (model_mask[idx][b] && (csr_pma_addr[idx][b] != pa[b])) begin
                match = 1'b0;
            end
        end
        return match;
    endfunction

    function automatic pma_mtype_e model_default(input pma_addr_t pa);
        logic [63:0] a;
        a = 64'(pa) & ~64'hFFF;
        if ((a & `PMA_DEVICE_MASK) == `PMA_DEVICE_BASE) begin
            return mtype_device;
        end else if ((a & `PMA_WT_MASK) == `PMA_WT_BASE) begin
            return mtype_write_through;
        end
        return mtype_write_back;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check_mtype(input pma_mtype_e exp);
        if (pma_resp_mtype !== exp) begin
            $display("[ERROR] %0d ns pma_resp_mtype expected %0d actual %0d",
                     $time, exp, pma_resp_mtype);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_namo(input bit exp);
        if (pma_resp_namo !== exp) begin
            $display("[ERROR] %0d ns pma_resp_namo expected %0b actual %0b",
                     $time, exp, pma_resp_namo);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic check_fault(input bit exp);
        if (pma_resp_fault !== exp) begin
            $display("[ERROR] %0d ns pma_resp_fault expected %0b actual %0b",
                     $time, exp, pma_resp_fault);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    // inputs change 1 ns after the edge, outputs are sampled 5 ns later
    task automatic tick();
        @(posedge core_clk);
        #1;
    endtask

    task automatic check_now();
        pma_mtype_e exp_mtype;
        logic       exp_namo;
        logic       found;
        #5;
        found = 1'b0;
        exp_namo = 1'b0;
        exp_mtype = model_default(pma_req_pa);
        for (int i = 0; i < `PMA_NUM_ENTRIES; i++) begin
            if (!found && model_hit(i, pma_req_pa)) begin
                found = 1'b1;
                exp_mtype = pma_mtype_e'(csr_pma_cfg[i][`PMA_CFG_MTYP_LSB +: 4]);
                exp_namo = csr_pma_cfg[i][`PMA_CFG_NAMO_BIT];
            end
        end
        check_mtype(exp_mtype);
        check_namo(exp_namo);
        check_fault(exp_mtype == mtype_black_hole);
    endtask

    task automatic lookup(input pma_addr_t pa);
        tick();
        pma_req_pa = pa;
        check_now();
    endtask

    // the same address is checked under the old mask and in the cycle after capture
    task automatic strobe_masks(input pma_addr_t pa);
        tick();
        reg_pma_we = 1'b1;
        pma_req_pa = pa;
        check_now();
        @(posedge core_clk);
        for (int i = 0; i < `PMA_NUM_ENTRIES; i++) begin
            model_mask[i] = mask_from_addr(csr_pma_addr[i]);
        end
        #1;
        reg_pma_we = 1'b0;
        check_now();
    endtask

    task automatic program_entry(input int idx, input pma_etyp_e etyp, input pma_mtype_e mtyp,
                                 input logic namo, input pma_addr_t base, input int k);
        csr_pma_cfg[idx] = make_cfg(etyp, mtyp, namo);
        csr_pma_addr[idx] = napot_addr(base, k);
        ent_base[idx] = base;
        ent_k[idx] = k;
    endtask

    // about half the lookups land inside one of the first num_regions entries
    task automatic random_lookups(input int count, input int num_regions);
        pma_addr_t pa;
        int        idx;
        for (int n = 0; n < count; n++) begin
            if (num_regions > 0 && lfsr_bit()) begin
                idx = int'(rand_bits(2)) % num_regions;
                pa = addr_in_region(ent_base[idx], ent_k[idx]);
            end else begin
                pa = rand_addr();
            end
            lookup(pa);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin
        pma_addr_t base;
        pma_addr_t pa;

        lfsr_state = 16'd56146;
        core_reset_n = 1'b0;
        reg_pma_we = 1'b0;
        pma_req_pa = '0;
        for (int i = 0; i < `PMA_NUM_ENTRIES; i++) begin
            csr_pma_cfg[i] = 8'h00;
            csr_pma_addr[i] = '0;
            model_mask[i] = '0;
            ent_base[i] = '0;
            ent_k[i] = `PMA_CHECK_LSB;
        end
        repeat (4) @(posedge core_clk);
        #1;
        core_reset_n = 1'b1;

        // masks are still zero, so a napot entry covers everything
        tick();
        program_entry(2, etyp_napot, mtype_write_through, 1'b1, rand_addr(), 16);
        random_lookups(200, 0);

        // no entry enabled, only the default map answers
        tick();
        for (int i = 0; i < `PMA_NUM_ENTRIES; i++) begin
            csr_pma_cfg[i] = 8'h00;
        end
        random_lookups(500, 0);

        for (int round = 0; round < 2; round++) begin
            tick();
            for (int i = 0; i < `PMA_NUM_ENTRIES; i++) begin
                program_entry(i, etyp_napot, pma_mtype_e'(4'(rand_bits(4))), lfsr_bit(),
                              rand_addr(), 12 + int'(rand_bits(4)));
            end
            strobe_masks(rand_addr());
            random_lookups(500, 4);
        end

        // nested regions around one base, the smallest has the highest priority
        tick();
        base = rand_addr();
        program_entry(0, etyp_napot, mtype_device, 1'b1, base, 13);
        program_entry(1, etyp_napot, mtype_write_through, 1'b0, base, 17);
        program_entry(2, etyp_napot, mtype_write_back, 1'b1, base, 22);
        program_entry(3, etyp_napot, pma_mtype_e'(4'd7), 1'b0, base, 28);
        strobe_masks(base);
        random_lookups(800, 4);

        tick();
        program_entry(0, etyp_napot, mtype_black_hole, 1'b1, rand_addr(), 16);
        for (int i = 1; i < `PMA_NUM_ENTRIES; i++) begin
            csr_pma_cfg[i] = 8'h00;
        end
        strobe_masks(rand_addr());
        random_lookups(600, 1);

        // shrink entry 0 without a strobe, the old 1 MiB mask stays in force
        tick();
        base = rand_addr();
        program_entry(0, etyp_napot, mtype_write_back, 1'b1, base, 20);
        strobe_masks(base);
        tick();
        csr_pma_addr[0] = napot_addr(base, 14);
        random_lookups(200, 1);
        pa = addr_in_region(base, 20);
        pa[19] = ~base[19];
        strobe_masks(pa);
        ent_k[0] = 14;
        random_lookups(200, 1);

        $display("All tests passed!");
        $finish;
    end

endmodule
